// ==== filelist.f ====
kick_pkg.sv
kick_frac_cen.sv
kick_dwnld.sv
kick_rom_slot.sv
kick_rom_arbiter.sv
kick_mem_top.sv
tb_sdram_model.sv
tb_kick_mem.sv

// ==== kick_dwnld.sv ====
// Turns loader byte writes into masked SDRAM word writes, reorders graphics addresses, routes PROM bytes
`timescale 1ns/1ps

module kick_dwnld #(
    parameter int unsigned scr_start  = 32'h1_0000,
    parameter int unsigned obj_start  = 32'h2_0000,
    parameter int unsigned pcm_start  = 32'h3_0000,
    parameter int unsigned prom_start = 32'h3_8000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             downloading,
    input  kick_pkg::ioctl_t ioctl,
    input  logic             sdram_ack,
    output kick_pkg::prog_t  prog,
    output logic             prom_we
);

    localparam logic [kick_pkg::ioctl_aw-1:0] scr_b  = scr_start[kick_pkg::ioctl_aw-1:0];
    localparam logic [kick_pkg::ioctl_aw-1:0] obj_b  = obj_start[kick_pkg::ioctl_aw-1:0];
    localparam logic [kick_pkg::ioctl_aw-1:0] pcm_b  = pcm_start[kick_pkg::ioctl_aw-1:0];
    localparam logic [kick_pkg::ioctl_aw-1:0] prom_b = prom_start[kick_pkg::ioctl_aw-1:0];

    kick_pkg::region_e             region;
    logic [kick_pkg::sdram_aw-1:0] pre_addr;   // Plain word address
    logic [kick_pkg::sdram_aw-1:0] prom_addr;  // Byte offset inside the PROM area
    logic [kick_pkg::sdram_aw-1:0] map_addr;
    logic                          wr_en;
    logic [kick_pkg::sdram_aw-1:0] addr_q;
    logic [7:0]                    data_q;
    logic [1:0]                    mask_q;
    logic                          we_q;

    assign wr_en     = downloading & ioctl.wr;
    assign pre_addr  = ioctl.addr[kick_pkg::sdram_aw:1];
    assign prom_addr = ioctl.addr[kick_pkg::sdram_aw-1:0] - prom_b[kick_pkg::sdram_aw-1:0];

    always_comb begin
        if (ioctl.addr < scr_b)       region = kick_pkg::region_main;
        else if (ioctl.addr < obj_b)  region = kick_pkg::region_scr;
        else if (ioctl.addr < pcm_b)  region = kick_pkg::region_obj;
        else if (ioctl.addr < prom_b) region = kick_pkg::region_pcm;
        else                          region = kick_pkg::region_prom;
    end

    // Tile and sprite data get their lines interleaved for 16-bit fetches
    always_comb begin
        map_addr = pre_addr;
        case (region)
            kick_pkg::region_scr: begin
                map_addr[0]   = ~pre_addr[3];
                map_addr[3:1] =  pre_addr[2:0];
            end
            kick_pkg::region_obj: begin
                map_addr[0]   = ~pre_addr[3];
                map_addr[1]   = ~pre_addr[4];
                map_addr[5:2] = {pre_addr[5], pre_addr[2:0]};
            end
            kick_pkg::region_prom: map_addr = prom_addr;
            default: map_addr = pre_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            addr_q <= map_addr;
            data_q <= ioctl.dout;
            mask_q <= ioctl.addr[0] ? 2'b01 : 2'b10;  // Odd bytes go to the upper lane
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q    <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_en && region == kick_pkg::region_prom;  // Single cycle
            if (wr_en && region != kick_pkg::region_prom) begin
                we_q <= 1'b1;
            end else if (sdram_ack) begin
                we_q <= 1'b0;
            end
        end
    end

    assign prog = '{addr: addr_q, data: data_q, mask: mask_q, we: we_q};

endmodule

// ==== kick_frac_cen.sv ====
// Fractional n/m clock-enable generator; cen[0] is the base strobe, higher taps divide it by 2, 4, 8
`timescale 1ns/1ps

module kick_frac_cen #(
    parameter int w = 4     // Number of enable taps
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [9:0]   n,
    input  logic [9:0]   m,
    output logic [w-1:0] cen
);

    logic [9:0]   acc;
    logic [10:0]  sum;
    logic [10:0]  rem;
    logic         base;
    logic [w-2:0] cnt;  // Base pulses seen so far

    assign sum  = {1'b0, acc} + {1'b0, n};
    assign rem  = sum - {1'b0, m};
    assign base = sum >= {1'b0, m};    // Strobe in the cycle the sum wraps

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cnt <= '0;
        end else begin
            acc <= base ? rem[9:0] : sum[9:0];
            if (base) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign cen[0] = base;

    // Tap i fires on every 2^i-th base pulse
    genvar i;
    generate
        for (i = 1; i < w; i++) begin : g_tap
            assign cen[i] = base & (&cnt[i-1:0]);
        end
    endgenerate

endmodule

// ==== kick_mem_top.sv ====
// Memory and timing core top: enable generator, ROM download path, three ROM slots and SDRAM arbiter
`timescale 1ns/1ps

module kick_mem_top #(
    parameter int unsigned scr_start  = 32'h1_0000,
    parameter int unsigned obj_start  = 32'h2_0000,
    parameter int unsigned pcm_start  = 32'h3_0000,
    parameter int unsigned prom_start = 32'h3_8000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             vsync60,     // High for 6MHz pixel clock, low for 6.144MHz
    output logic             pxl2_cen,
    output logic             pxl_cen,
    output logic             cpu_cen,
    // ROM download
    input  logic             downloading,
    output logic             dwnld_busy,
    input  kick_pkg::ioctl_t ioctl,
    output kick_pkg::prog_t  prog,
    output logic             prom_we,
    // Scroll tiles
    input  logic             scr_cs,
    input  logic [12:0]      scr_addr,
    output logic [15:0]      scr_data,
    output logic             scr_ok,
    // Objects
    input  logic             obj_cs,
    input  logic [13:0]      obj_addr,
    output logic [15:0]      obj_data,
    output logic             obj_ok,
    // Main CPU
    input  logic             main_cs,
    input  logic [15:0]      main_addr,
    output logic [7:0]       main_data,
    output logic             main_ok,
    // SDRAM read port
    output logic             sdram_req,
    output logic [21:0]      sdram_addr,
    input  logic             sdram_ack,
    input  logic             data_rdy,
    input  logic [15:0]      data_read
);

    localparam int taps = 3;

    logic [taps-1:0]           cen;
    kick_pkg::slot_req_t [2:0] slot_req;   // 0 scroll, 1 object, 2 main
    logic [2:0]                fill;
    logic [15:0]               fill_data;

    assign dwnld_busy = downloading;
    assign pxl2_cen   = cen[0];  // ~12MHz
    assign pxl_cen    = cen[1];  // ~6MHz
    assign cpu_cen    = cen[2];

    kick_frac_cen #(.w(taps)) u_cen (
        .clk    ( clk                          ),
        .rst_n  ( rst_n                        ),
        .n      ( vsync60 ? 10'd1 : 10'd32     ),
        .m      ( vsync60 ? 10'd4 : 10'd125    ),
        .cen    ( cen                          )
    );

    kick_dwnld #(
        .scr_start  ( scr_start  ),
        .obj_start  ( obj_start  ),
        .pcm_start  ( pcm_start  ),
        .prom_start ( prom_start )
    ) u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl       ( ioctl       ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .prom_we     ( prom_we     )
    );

    kick_rom_slot #(.aw(13), .dw(16), .offset(scr_start >> 1)) u_scr_slot (
        .clk ( clk ), .rst_n ( rst_n ),
        .cs ( scr_cs ), .addr ( scr_addr ), .data ( scr_data ), .ok ( scr_ok ),
        .req ( slot_req[0] ), .fill ( fill[0] ), .fill_data ( fill_data )
    );

    kick_rom_slot #(.aw(14), .dw(16), .offset(obj_start >> 1)) u_obj_slot (
        .clk ( clk ), .rst_n ( rst_n ),
        .cs ( obj_cs ), .addr ( obj_addr ), .data ( obj_data ), .ok ( obj_ok ),
        .req ( slot_req[1] ), .fill ( fill[1] ), .fill_data ( fill_data )
    );

    kick_rom_slot #(.aw(16), .dw(8), .offset(0)) u_main_slot (
        .clk ( clk ), .rst_n ( rst_n ),
        .cs ( main_cs ), .addr ( main_addr ), .data ( main_data ), .ok ( main_ok ),
        .req ( slot_req[2] ), .fill ( fill[2] ), .fill_data ( fill_data )
    );

    kick_rom_arbiter #(.slots(3)) u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .req         ( slot_req    ),
        .fill        ( fill        ),
        .fill_data   ( fill_data   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

// ==== kick_pkg.sv ====
// Shared widths, region and arbiter enums, and bus structs for the memory core and its testbench
package kick_pkg;

    // SDRAM word address and loader byte address widths
    localparam int sdram_aw = 22;
    localparam int ioctl_aw = 25;

    // Loader byte write, as presented by the ioctl port
    typedef struct packed {
        logic [ioctl_aw-1:0] addr;  // Byte address
        logic [7:0]          dout;  // Byte to program
        logic                wr;    // Write strobe
    } ioctl_t;

    // SDRAM programming write
    typedef struct packed {
        logic [sdram_aw-1:0] addr;  // Word address, or PROM byte offset
        logic [7:0]          data;
        logic [1:0]          mask;  // Active low lane mask
        logic                we;    // Held until sdram_ack
    } prog_t;

    // Refill request from one slot to the arbiter
    typedef struct packed {
        logic                req;
        logic [sdram_aw-1:0] addr;  // Absolute SDRAM word address
    } slot_req_t;

    // Loader regions, in ascending address order
    typedef enum logic [2:0] {
        region_main,
        region_scr,
        region_obj,
        region_pcm,
        region_prom
    } region_e;

    // SDRAM read sequence
    typedef enum logic [1:0] {
        arb_idle,       // Waiting for a slot request
        arb_wait_ack,   // sdram_req up
        arb_wait_data   // Acked, data_rdy pending
    } arb_state_e;

endpackage

// ==== kick_rom_arbiter.sv ====
// Fixed-priority SDRAM read arbiter; lowest slot index wins, one request outstanding at a time
`timescale 1ns/1ps

module kick_rom_arbiter #(
    parameter int slots = 3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  kick_pkg::slot_req_t [slots-1:0]     req,
    output logic [slots-1:0]                    fill,
    output logic [15:0]                         fill_data,
    output logic                                sdram_req,
    output logic [kick_pkg::sdram_aw-1:0]       sdram_addr,
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    input  logic [15:0]                         data_read
);

    localparam int gw = (slots > 1) ? $clog2(slots) : 1;

    kick_pkg::arb_state_e state;
    logic [gw-1:0]        pick;     // Lowest requesting slot
    logic [gw-1:0]        grant;
    logic                 any_req;
    logic                 start;

    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = slots - 1; i >= 0; i--) begin
            if (req[i].req) begin
                pick    = gw'(i);
                any_req = 1'b1;
            end
        end
    end

    // No new reads while the loader owns the SDRAM
    assign start = state == kick_pkg::arb_idle && any_req && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= kick_pkg::arb_idle;
            grant     <= '0;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                kick_pkg::arb_idle: begin
                    if (start) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= kick_pkg::arb_wait_ack;
                    end
                end
                kick_pkg::arb_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= kick_pkg::arb_wait_data;
                    end
                end
                kick_pkg::arb_wait_data: begin
                    if (data_rdy) begin
                        state <= kick_pkg::arb_idle;
                    end
                end
                default: state <= kick_pkg::arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= req[pick].addr;
        end
    end

    // Fill strobe in the data_rdy cycle so the slot's request drops before the next grant
    always_comb begin
        fill = '0;
        if (state == kick_pkg::arb_wait_data && data_rdy) begin
            fill[grant] = 1'b1;
        end
    end

    assign fill_data = data_read;   // Only the granted slot samples it

endmodule

// ==== kick_rom_slot.sv ====
// One ROM client slot with a single-word cache; requests a refill on a miss and picks a byte lane
`timescale 1ns/1ps

module kick_rom_slot #(
    parameter int          aw     = 16,  // Client address width
    parameter int          dw     = 8,   // 8 or 16
    parameter int unsigned offset = 0    // SDRAM word offset of the region
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cs,
    input  logic [aw-1:0]         addr,
    output logic [dw-1:0]         data,
    output logic                  ok,
    output kick_pkg::slot_req_t   req,
    input  logic                  fill,
    input  logic [15:0]           fill_data
);

    // 8-bit clients use byte addresses, bit 0 selects the lane
    localparam int ww = (dw == 8) ? aw - 1 : aw;
    localparam logic [kick_pkg::sdram_aw-1:0] off_w = offset[kick_pkg::sdram_aw-1:0];

    logic [ww-1:0]                 word_addr;
    logic [kick_pkg::sdram_aw-1:0] word_abs;
    logic [kick_pkg::sdram_aw-1:0] cache_addr;
    logic [15:0]                   cache_data;
    logic                          cache_valid;

    generate
        if (dw == 8) begin : g_byte
            assign word_addr = addr[aw-1:1];
            assign data      = addr[0] ? cache_data[15:8] : cache_data[7:0];
        end else begin : g_word
            assign word_addr = addr;
            assign data      = cache_data;
        end
    endgenerate

    assign word_abs = off_w + {{(kick_pkg::sdram_aw-ww){1'b0}}, word_addr};

    assign ok  = cache_valid && cache_addr == word_abs;
    assign req = '{req: cs & ~ok, addr: word_abs};  // Up until the fill lands

    always_ff @(posedge clk) begin
        if (fill) begin
            cache_addr <= word_abs;  // Client holds addr steady while waiting
            cache_data <= fill_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_valid <= 1'b0;
        end else if (fill) begin
            cache_valid <= 1'b1;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_kick_mem -f filelist.f
./obj_dir/Vtb_kick_mem | tee sim.log

grep -q "All checks passed" sim.log

// ==== tb_kick_mem.sv ====
// Testbench for the memory core; checks enable rates, download mapping, cached reads and arbitration
`timescale 1ns/1ps

module tb_kick_mem;

    localparam int unsigned scr_start  = 32'h1_0000;
    localparam int unsigned obj_start  = 32'h2_0000;
    localparam int unsigned pcm_start  = 32'h3_0000;
    localparam int unsigned prom_start = 32'h3_8000;
    localparam int unsigned dl_base [4] = '{32'h0, scr_start, obj_start, prom_start};

    logic             clk = 1'b0;
    logic             rst_n, vsync60, downloading, dwnld_busy, prom_we;
    logic             pxl2_cen, pxl_cen, cpu_cen;
    kick_pkg::ioctl_t ioctl;
    kick_pkg::prog_t  prog, wr_last;
    logic             scr_cs, obj_cs, main_cs, scr_ok, obj_ok, main_ok;
    logic [12:0]      scr_addr;
    logic [13:0]      obj_addr;
    logic [15:0]      main_addr, scr_data, obj_data, data_read;
    logic [7:0]       main_data;
    logic             sdram_req, sdram_ack, data_rdy, req_q, rd_open;
    logic [21:0]      sdram_addr;
    int               wr_cnt, req_rises;
    int               n_pass = 0;
    int               n_fail = 0;
    int               seed = 81;
    string            dl_name [4] = '{"main", "scroll", "object", "prom"};

    always #10 clk = ~clk;

    kick_mem_top #(
        .scr_start(scr_start), .obj_start(obj_start),
        .pcm_start(pcm_start), .prom_start(prom_start)
    ) DUT (.*);

    tb_sdram_model u_sdram (.*);

    // Read bookkeeping for the one-outstanding rule and the hit test
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            rd_open   <= 1'b0;
            req_rises <= 0;
        end else begin
            req_q <= sdram_req;
            if (sdram_req && !req_q) req_rises <= req_rises + 1;
            if (sdram_req) rd_open <= 1'b1;
            else if (data_rdy) rd_open <= 1'b0;
        end
    end

    task automatic protocol_error(input string what);
        n_fail++;
        $display("ERROR %s", what);
    endtask

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n) $rose(sdram_req) |-> !rd_open)
        else protocol_error("sdram_req rose again before the previous data_rdy");
    a_dl_block: assert property (@(posedge clk) disable iff (!rst_n) downloading |-> !sdram_req)
        else protocol_error("sdram_req was high while downloading");
    a_busy: assert property (@(posedge clk) disable iff (!rst_n) dwnld_busy == downloading)
        else protocol_error("dwnld_busy did not follow downloading");
    a_we_delay: assert property (@(posedge clk) disable iff (!rst_n)
        downloading && ioctl.wr |=> prog.we || prom_we)
        else protocol_error("no write strobe one cycle after ioctl.wr");
    a_we_drop: assert property (@(posedge clk) disable iff (!rst_n) prog.we && sdram_ack |=> !prog.we)
        else protocol_error("prog.we stayed high after sdram_ack");

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) begin
            n_pass++;
            $display("PASS %s expected %0h actual %0h", name, exp, act);
        end else begin
            n_fail++;
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    function automatic logic [15:0] rom_word(input logic [21:0] waddr);
        return waddr[15:0] ^ 16'h5A5A;
    endfunction

    function automatic logic [7:0] main_byte(input logic [15:0] a);
        logic [15:0] w;
        w = rom_word(22'(a[15:1]));
        return a[0] ? w[15:8] : w[7:0];  // Odd bytes sit in the upper lane
    endfunction

    // Expected SDRAM word address (or PROM offset) for a loader byte address
    function automatic logic [21:0] dl_addr(input logic [24:0] a);
        logic [21:0] w;
        logic [21:0] r;
        w = a[22:1];
        r = w;
        if (a >= 25'(prom_start)) begin
            r = a[21:0] - 22'(prom_start);
        end else if (a >= 25'(obj_start) && a < 25'(pcm_start)) begin
            r[0]   = ~w[3];
            r[1]   = ~w[4];
            r[5:2] = {w[5], w[2:0]};
        end else if (a >= 25'(scr_start)) begin
            r[0]   = ~w[3];
            r[3:1] = w[2:0];
        end
        return r;
    endfunction

    function automatic logic flag(input int which);
        case (which)
            0: return scr_ok;
            1: return obj_ok;
            2: return main_ok;
            3: return scr_ok && obj_ok && main_ok;
            4: return prog.we || prom_we;
            default: return !prog.we;
        endcase
    endfunction

    task automatic wait_for(input int which, input string what, output logic seen);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!flag(which) && t < 200);
        seen = flag(which);
        if (!seen) protocol_error({"timed out waiting for ", what});
    endtask

    task automatic apply_reset(input logic v60);
        @(posedge clk);
        rst_n   <= 1'b0;
        vsync60 <= v60;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    initial begin
        rst_n       = 1'b0;
        vsync60     = 1'b1;
        downloading = 1'b0;
        ioctl       = '0;
        scr_cs      = 1'b0;
        obj_cs      = 1'b0;
        main_cs     = 1'b0;
        scr_addr    = '0;
        obj_addr    = '0;
        main_addr   = '0;
        begin : run_tests
            logic [31:0] r;
            logic [24:0] a;
            logic        seen;
            int          cnt [3];
            int          exp_p;
            int          wr_seen;
            int          rises;
            for (int v = 1; v >= 0; v--) begin
                apply_reset(v[0]);
                cnt = '{0, 0, 0};
                repeat (1000) begin
                    @(negedge clk);
                    cnt[0] += 32'(pxl2_cen);
                    cnt[1] += 32'(pxl_cen);
                    cnt[2] += 32'(cpu_cen);
                end
                exp_p = v == 1 ? 1000 * 1 / 4 : 1000 * 32 / 125;
                check($sformatf("pxl2_cen count vsync60=%0d", v), exp_p, cnt[0]);
                check($sformatf("pxl_cen count vsync60=%0d", v), exp_p / 2, cnt[1]);
                check($sformatf("cpu_cen count vsync60=%0d", v), exp_p / 4, cnt[2]);
            end
            @(posedge clk);
            downloading <= 1'b1;
            for (int i = 0; i < 4; i++) begin
                r = $random(seed);
                a = 25'(dl_base[i] + (r & (i == 3 ? 32'hFF : 32'hFFFF)));
                wr_seen = wr_cnt;
                @(posedge clk);
                ioctl <= '{addr: a, dout: r[23:16], wr: 1'b1};
                @(posedge clk);
                ioctl.wr <= 1'b0;
                wait_for(4, {dl_name[i], " write strobe"}, seen);
                if (!seen) disable run_tests;
                check({"download ", dl_name[i], " addr"}, 32'(dl_addr(a)), 32'(prog.addr));
                check({"download ", dl_name[i], " data"}, 32'(r[23:16]), 32'(prog.data));
                if (i == 3) begin
                    check("download prom keeps prog.we low", 0, 32'(prog.we));
                    @(negedge clk);
                    check("download prom_we single cycle", 0, 32'(prom_we));
                end else begin
                    check({"download ", dl_name[i], " mask"}, a[0] ? 32'h1 : 32'h2,
                          32'(prog.mask));
                    wait_for(5, {dl_name[i], " write ack"}, seen);
                    if (!seen) disable run_tests;
                    check({"download ", dl_name[i], " logged"}, wr_seen + 1, wr_cnt);
                    check({"download ", dl_name[i], " logged addr"}, 32'(dl_addr(a)),
                          32'(wr_last.addr));
                end
                repeat (8) @(posedge clk);   // Loader gap
            end
            downloading <= 1'b0;
            r = $random(seed);
            @(posedge clk);
            scr_cs   <= 1'b1;
            scr_addr <= r[12:0];
            wait_for(0, "scroll read", seen);
            if (!seen) disable run_tests;
            check("scroll read", 32'(rom_word(22'(scr_start >> 1) + 22'(scr_addr))), 32'(scr_data));
            check("scroll read address", 32'(22'(scr_start >> 1) + 22'(scr_addr)),
                  32'(sdram_addr));
            rises = req_rises;
            @(posedge clk);
            scr_cs <= 1'b0;
            @(posedge clk);
            scr_cs <= 1'b1;
            @(negedge clk);
            check("scroll hit ok", 1, 32'(scr_ok));
            repeat (4) @(negedge clk);
            check("scroll hit without request", rises, req_rises);
            r = $random(seed);
            @(posedge clk);
            scr_addr  <= scr_addr ^ 13'h5;  // Force a scroll miss
            obj_addr  <= r[13:0];
            main_addr <= r[31:16];
            obj_cs    <= 1'b1;
            main_cs   <= 1'b1;
            wait_for(3, "three concurrent reads", seen);
            if (!seen) disable run_tests;
            check("concurrent scroll", 32'(rom_word(22'(scr_start >> 1) + 22'(scr_addr))),
                  32'(scr_data));
            check("concurrent object", 32'(rom_word(22'(obj_start >> 1) + 22'(obj_addr))),
                  32'(obj_data));
            check("concurrent main", 32'(main_byte(main_addr)), 32'(main_data));
            @(posedge clk);
            downloading <= 1'b1;
            main_addr   <= main_addr ^ 16'h0003;  // Other word and lane, cache miss
            repeat (20) @(negedge clk);
            check("main blocked while downloading", 0, 32'(main_ok));
            @(posedge clk);
            downloading <= 1'b0;
            wait_for(2, "main read after download", seen);
            if (!seen) disable run_tests;
            check("main after download", 32'(main_byte(main_addr)), 32'(main_data));
            @(posedge clk);
            scr_cs  <= 1'b0;
            obj_cs  <= 1'b0;
            main_cs <= 1'b0;
            repeat (4) @(posedge clk);
        end
        $display("Summary %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb_sdram_model.sv ====
// Behavioral SDRAM for the testbench; acks reads and programming writes, returns address-based words
`timescale 1ns/1ps

module tb_sdram_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sdram_req,
    input  logic [kick_pkg::sdram_aw-1:0] sdram_addr,
    input  kick_pkg::prog_t               prog,
    output logic                          sdram_ack,
    output logic                          data_rdy,
    output logic [15:0]                   data_read,
    output int                            wr_cnt,   // Programming writes taken
    output kick_pkg::prog_t               wr_last
);

    logic [kick_pkg::sdram_aw-1:0] rd_addr;
    logic [1:0]                    delay;   // Cycles left until data_rdy
    logic                          idle;

    assign idle = !sdram_ack && !data_rdy && delay == 2'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            delay     <= '0;
            rd_addr   <= '0;
            wr_cnt    <= 0;
            wr_last   <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (delay != 2'd0) begin
                delay <= delay - 1'b1;
                if (delay == 2'd1) begin
                    data_rdy  <= 1'b1;  // Third cycle after the ack
                    data_read <= rd_addr[15:0] ^ 16'h5A5A;
                end
            end
            if (idle && sdram_req) begin
                sdram_ack <= 1'b1;
                rd_addr   <= sdram_addr;
                delay     <= 2'd3;
            end else if (idle && prog.we) begin
                sdram_ack <= 1'b1;
                wr_cnt    <= wr_cnt + 1;
                wr_last   <= prog;
            end
        end
    end

endmodule
